// ==== source/simon_cfg.svh ====
`ifndef SIMON_CFG_SVH
`define SIMON_CFG_SVH

// samples a button must stay stable before its new level is taken
`define DEBOUNCE_CYCLES 8

// length of one colour tone played by simon
`define TONE_CYCLES 256

// dark silence after each simon tone
`define GAP_CYCLES 64

// length of one melody note and of the pause in front of a melody
`define NOTE_CYCLES 128

// speaker half period for tone index 0, in clock cycles
`define TONE_BASE_HALF 6

// extra half period per tone index step
`define TONE_STEP_HALF 2

// feedback mask of the 16 bit galois lfsr
`define LFSR_TAPS 16'hB400

// lfsr start value after reset, must never be zero
`define LFSR_SEED_INIT 16'hACE1

// score width, also bounds the longest sequence
`define SCORE_W 8

`endif

// ==== source/simonPkg.sv ====
`default_nettype none

`include "simon_cfg.svh"

package simonPkg;

	// one of the four colours, also the button index
	typedef logic [1:0] color_t;
	// one bit per colour, indexed by colour
	typedef logic [3:0] buttons_t;
	// 0 to 3 are colour tones, 4 to 7 melody notes
	typedef logic [2:0] toneIdx_t;
	// completed rounds
	typedef logic [`SCORE_W-1:0] score_t;
	typedef logic [15:0] lfsr_t;

	typedef enum logic [3:0] {
		Idle,
		Randomize,
		SimonPlay,
		SimonGap,
		PlayerInit,
		PlayerEntry,
		PlayerRelease,
		PlayerCheck,
		WinMelody,
		LoseMelody
	} gameState_t;

	// sequence generator commands
	typedef struct packed {
		logic step;
		logic rerun;
		logic randomize;
	} seqCtl_t;

	typedef struct packed {
		logic enable;
		toneIdx_t idx;
	} toneReq_t;

	typedef struct packed {
		logic on;
		color_t color;
	} ledDrive_t;

endpackage

`default_nettype wire

// ==== source/buttonDebouncer.sv ====
`default_nettype none

`include "simon_cfg.svh"

module buttonDebouncer
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input buttons_t buttonsN,
	output buttons_t held,
	output buttons_t pressed
);

	localparam int NumButtons = $bits(buttons_t);
	localparam int CountW = $clog2(`DEBOUNCE_CYCLES + 1);

	// buttons are active low, flip them while syncing
	buttons_t raw;
	// held from the previous cycle for edge detect
	buttons_t heldLast;
	// per button count of samples that disagree with held
	logic [CountW-1:0] stable [NumButtons];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			raw <= '0;
			held <= '0;
			heldLast <= '0;
			for (int i = 0; i < NumButtons; i++) begin
				stable[i] <= '0;
			end
		end else begin
			raw <= ~buttonsN;
			heldLast <= held;
			for (int i = 0; i < NumButtons; i++) begin
				// any sample matching held restarts the wait
				if (raw[i] == held[i]) begin
					stable[i] <= '0;
				end else if (stable[i] == CountW'(`DEBOUNCE_CYCLES - 1)) begin
					stable[i] <= '0;
					held[i] <= raw[i];
				end else begin
					stable[i] <= stable[i] + 1'b1;
				end
			end
		end
	end

	// one cycle pulse when a button becomes held
	assign pressed = held & ~heldLast;

endmodule

`default_nettype wire

// ==== source/sequenceGenerator.sv ====
`default_nettype none

`include "simon_cfg.svh"

module sequenceGenerator
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input seqCtl_t ctl,
	output color_t color
);

	// live generator state
	lfsr_t lfsr;
	// start of the current game, replayed by rerun
	lfsr_t seed;
	lfsr_t lfsrNext;

	// galois form, shift right and fold the taps in on a one
	always_comb begin
		if (lfsr[0]) begin
			lfsrNext = (lfsr >> 1) ^ lfsr_t'(`LFSR_TAPS);
		end else begin
			lfsrNext = lfsr >> 1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lfsr <= lfsr_t'(`LFSR_SEED_INIT);
			seed <= lfsr_t'(`LFSR_SEED_INIT);
		end else if (ctl.rerun) begin
			// back to the first colour of the game
			lfsr <= seed;
		end else if (ctl.randomize) begin
			// free run while the start button is down
			// and keep every value as the new seed
			lfsr <= lfsrNext;
			seed <= lfsrNext;
		end else if (ctl.step) begin
			lfsr <= lfsrNext;
		end
	end

	// colour is taken from the low two bits
	assign color = lfsr[1:0];

endmodule

`default_nettype wire

// ==== source/toneTimer.sv ====
`default_nettype none

`include "simon_cfg.svh"

module toneTimer (
	input logic clk,
	input logic reset,
	input logic restart,
	output logic toneDone,
	output logic gapDone,
	output logic noteDone
);

	// longest phase sets the counter range
	localparam int LongA = (`TONE_CYCLES > `GAP_CYCLES) ? `TONE_CYCLES : `GAP_CYCLES;
	localparam int Longest = (LongA > `NOTE_CYCLES) ? LongA : `NOTE_CYCLES;
	localparam int CountW = $clog2(Longest + 1);

	// cycles spent in the current phase
	logic [CountW-1:0] count;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
		end else if (restart) begin
			count <= '0;
		end else if (count != CountW'(Longest)) begin
			// stops at the top so the flags stay up
			count <= count + 1'b1;
		end
	end

	// a flag is up in the last cycle of its phase and after
	// so a phase started by restart lasts exactly N cycles
	assign toneDone = (count >= CountW'(`TONE_CYCLES - 1));
	assign gapDone = (count >= CountW'(`GAP_CYCLES - 1));
	assign noteDone = (count >= CountW'(`NOTE_CYCLES - 1));

endmodule

`default_nettype wire

// ==== source/toneSynth.sv ====
`default_nettype none

`include "simon_cfg.svh"

module toneSynth
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input toneReq_t req,
	output logic speaker
);

	localparam int HalfMax = `TONE_BASE_HALF + 7 * `TONE_STEP_HALF;
	localparam int HalfW = $clog2(HalfMax + 1);

	logic [HalfW-1:0] halfPeriod;
	// cycles since the last edge of the square wave
	logic [HalfW-1:0] phase;
	// tone played last cycle, a change restarts the phase
	toneIdx_t idxLast;
	logic wave;

	// higher index gives a longer period and a lower pitch
	assign halfPeriod = HalfW'(`TONE_BASE_HALF + req.idx * `TONE_STEP_HALF);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= '0;
			idxLast <= '0;
			wave <= 1'b0;
		end else begin
			idxLast <= req.idx;
			if (!req.enable) begin
				phase <= '0;
				wave <= 1'b0;
			end else if (req.idx != idxLast) begin
				phase <= '0;
			end else if (phase == halfPeriod - 1'b1) begin
				phase <= '0;
				wave <= ~wave;
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	// silent right away once the request drops
	assign speaker = wave & req.enable;

endmodule

`default_nettype wire

// ==== source/gameControl.sv ====
`default_nettype none

module gameControl
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input buttons_t held,
	input buttons_t pressed,
	input color_t color,
	input logic toneDone,
	input logic gapDone,
	input logic noteDone,
	output seqCtl_t seqCtl,
	output logic timerRestart,
	output toneReq_t toneReq,
	output ledDrive_t led,
	output score_t score
);

	gameState_t state;
	gameState_t stateNext;
	// melody position, 0 is the pause and 1 to 3 the notes
	logic [1:0] noteIdx;
	logic [1:0] noteNext;
	// colours simon has finished this round
	score_t played;
	score_t playedNext;
	// colours the player got right this round
	score_t guessed;
	score_t guessedNext;
	score_t scoreNext;
	color_t lastBtn;
	logic latchBtn;

	// lowest pressed colour wins if two rise together
	function automatic color_t pressedColor(input buttons_t b);
		color_t c;
		c = '0;
		for (int i = $bits(buttons_t) - 1; i >= 0; i--) begin
			if (b[i]) begin
				c = color_t'(i);
			end
		end
		return c;
	endfunction

	always_comb begin
		stateNext = state;
		noteNext = noteIdx;
		playedNext = played;
		guessedNext = guessed;
		scoreNext = score;
		seqCtl = '0;
		timerRestart = 1'b0;
		latchBtn = 1'b0;
		case (state)
			Idle: begin
				// colour 0 doubles as the start button
				if (pressed[0]) begin
					stateNext = Randomize;
				end
			end
			Randomize: begin
				// how long the button is held picks the seed
				seqCtl.randomize = held[0];
				if (!held[0]) begin
					seqCtl.rerun = 1'b1;
					timerRestart = 1'b1;
					playedNext = '0;
					stateNext = SimonPlay;
				end
			end
			SimonPlay: begin
				if (toneDone) begin
					timerRestart = 1'b1;
					stateNext = SimonGap;
				end
			end
			SimonGap: begin
				if (gapDone) begin
					// a round plays score+1 colours
					if (played == score) begin
						playedNext = '0;
						stateNext = PlayerInit;
					end else begin
						playedNext = played + 1'b1;
						seqCtl.step = 1'b1;
						timerRestart = 1'b1;
						stateNext = SimonPlay;
					end
				end
			end
			PlayerInit: begin
				// replay the round from the seed for checking
				seqCtl.rerun = 1'b1;
				guessedNext = '0;
				stateNext = PlayerEntry;
			end
			PlayerEntry: begin
				// only a fresh press counts, a button kept down from before is ignored
				if (|pressed) begin
					latchBtn = 1'b1;
					stateNext = PlayerRelease;
				end
			end
			PlayerRelease: begin
				if (held == '0) begin
					stateNext = PlayerCheck;
				end
			end
			PlayerCheck: begin
				timerRestart = 1'b1;
				noteNext = '0;
				if (lastBtn == color) begin
					seqCtl.step = 1'b1;
					if (guessed == score) begin
						stateNext = WinMelody;
					end else begin
						guessedNext = guessed + 1'b1;
						stateNext = PlayerEntry;
					end
				end else begin
					stateNext = LoseMelody;
				end
			end
			WinMelody, LoseMelody: begin
				if (noteDone) begin
					timerRestart = 1'b1;
					if (noteIdx == 2'd3) begin
						noteNext = '0;
						if (state == WinMelody) begin
							// next round starts again from the seed
							scoreNext = score + 1'b1;
							seqCtl.rerun = 1'b1;
							stateNext = SimonPlay;
						end else begin
							scoreNext = '0;
							stateNext = Idle;
						end
					end else begin
						noteNext = noteIdx + 1'b1;
					end
				end
			end
			default: begin
				stateNext = Idle;
			end
		endcase
	end

	// leds and speaker follow the state directly
	always_comb begin
		led = '0;
		toneReq = '0;
		case (state)
			SimonPlay: begin
				led.on = 1'b1;
				led.color = color;
				toneReq.enable = 1'b1;
				toneReq.idx = {1'b0, color};
			end
			PlayerRelease: begin
				led.on = |held;
				led.color = lastBtn;
				toneReq.enable = |held;
				toneReq.idx = {1'b0, lastBtn};
			end
			// rising notes 4 5 6
			WinMelody: begin
				toneReq.enable = (noteIdx != 2'd0);
				toneReq.idx = 3'd3 + {1'b0, noteIdx};
			end
			// falling notes 2 1 0
			LoseMelody: begin
				toneReq.enable = (noteIdx != 2'd0);
				toneReq.idx = 3'd3 - {1'b0, noteIdx};
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= Idle;
			noteIdx <= '0;
			played <= '0;
			guessed <= '0;
			score <= '0;
		end else begin
			state <= stateNext;
			noteIdx <= noteNext;
			played <= playedNext;
			guessed <= guessedNext;
			score <= scoreNext;
		end
	end

	// colour of the press being echoed
	always_ff @(posedge clk) begin
		if (latchBtn) begin
			lastBtn <= pressedColor(pressed);
		end
	end

endmodule

`default_nettype wire

// ==== source/simonTop.sv ====
`default_nettype none

module simonTop
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input buttons_t buttonsN,
	output ledDrive_t led,
	output logic speaker,
	output score_t score
);

	buttons_t held;
	buttons_t pressed;
	color_t color;
	seqCtl_t seqCtl;
	logic timerRestart;
	logic toneDone;
	logic gapDone;
	logic noteDone;
	toneReq_t toneReq;

	// raw active low buttons in, clean held and pressed out
	buttonDebouncer debouncer (
		.clk(clk),
		.reset(reset),
		.buttonsN(buttonsN),
		.held(held),
		.pressed(pressed)
	);

	sequenceGenerator generator (
		.clk(clk),
		.reset(reset),
		.ctl(seqCtl),
		.color(color)
	);

	// one timer shared by tones, gaps and melody notes
	toneTimer timer (
		.clk(clk),
		.reset(reset),
		.restart(timerRestart),
		.toneDone(toneDone),
		.gapDone(gapDone),
		.noteDone(noteDone)
	);

	toneSynth synth (
		.clk(clk),
		.reset(reset),
		.req(toneReq),
		.speaker(speaker)
	);

	gameControl control (
		.clk(clk),
		.reset(reset),
		.held(held),
		.pressed(pressed),
		.color(color),
		.toneDone(toneDone),
		.gapDone(gapDone),
		.noteDone(noteDone),
		.seqCtl(seqCtl),
		.timerRestart(timerRestart),
		.toneReq(toneReq),
		.led(led),
		.score(score)
	);

endmodule

`default_nettype wire

// ==== testbench/simonTop_chk.sv ====
`default_nettype none

`include "simon_cfg.svh"

module simonTopChk
	import simonPkg::*;
(
	input logic clk,
	input logic reset,
	input toneReq_t toneReq,
	input logic speaker,
	input score_t score,
	input ledDrive_t led,
	input gameState_t state
);

	// no sound unless the controller asks for a tone
	speakerQuiet: assert property (
		@(posedge clk) disable iff (reset)
		!toneReq.enable |-> !speaker
	) else $error("speaker high while no tone is requested");

	// score only moves on the edge that leaves a melody
	scoreStable: assert property (
		@(posedge clk) disable iff (reset)
		(score != $past(score)) |->
			($past(state) == WinMelody || $past(state) == LoseMelody)
	) else $error("score changed outside the end of a melody");

	// board stays dark while waiting for a start press
	idleDark: assert property (
		@(posedge clk) disable iff (reset)
		(state == Idle) |-> !led.on
	) else $error("led lit in idle");

endmodule

`default_nettype wire

// ==== testbench/simonTb.sv ====
`default_nettype none

`include "simon_cfg.svh"

module simonTb
	import simonPkg::*;
();

	localparam int Rounds = 7;
	localparam int Colours = Rounds * (Rounds + 1) / 2;
	localparam int PressCycles = 4 * (`DEBOUNCE_CYCLES + 24);
	localparam int TimeoutCycles = 2 * (Colours * (`TONE_CYCLES + 2 * `GAP_CYCLES)
		+ Rounds * 4 * `NOTE_CYCLES + (Colours + Rounds) * PressCycles) + 4000;

	logic clk;
	logic reset;
	buttons_t buttonsN;
	ledDrive_t led;
	logic speaker;
	score_t score;

	integer seed;
	int valueErrors;
	int otherErrors;
	int cycles;
	// tone watcher state
	int melodyHalf;
	int lastHalf;
	int sinceEdge;
	int edgeCount;
	logic armed;
	logic spkLast;
	// colours of this round and of the one before
	color_t seq [Rounds];
	color_t prevSeq [Rounds];

	simonTop UUT (
		.clk(clk),
		.reset(reset),
		.buttonsN(buttonsN),
		.led(led),
		.speaker(speaker),
		.score(score)
	);

	bind simonTop simonTopChk chk (
		.clk(clk),
		.reset(reset),
		.toneReq(toneReq),
		.speaker(speaker),
		.score(score),
		.led(led),
		.state(control.state)
	);

	always #2 clk = ~clk;

	// expected half period of a tone index
	function automatic int halfFor(input toneIdx_t idx);
		return `TONE_BASE_HALF + int'(idx) * `TONE_STEP_HALF;
	endfunction

	task automatic colorMatch(input string name, input color_t got, input color_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic scoreMatch(input string name, input score_t got, input score_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic bitMatch(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			valueErrors++;
		end
	endtask

	task automatic reportProblem(input string text);
		$display("%s", text);
		otherErrors++;
	endtask

	// speaker period follows the lit colour or the melody note in a window
	always @(negedge clk) begin
		int curHalf;
		logic expBit;
		if (reset) begin
			armed = 1'b0;
			lastHalf = 0;
		end else begin
			curHalf = led.on ? halfFor({1'b0, led.color}) : melodyHalf;
			if (curHalf == 0 || curHalf != lastHalf) begin
				armed = 1'b0;
			end else if (!armed) begin
				// first edge sets the phase reference
				if (speaker != spkLast) begin
					armed = 1'b1;
					sinceEdge = 0;
				end
			end else begin
				sinceEdge++;
				expBit = (sinceEdge == curHalf) ? ~spkLast : spkLast;
				bitMatch("speaker", speaker, expBit);
				if (speaker != expBit) begin
					armed = 1'b0;
				end else if (speaker != spkLast) begin
					sinceEdge = 0;
					edgeCount++;
				end
			end
			lastHalf = curHalf;
		end
		spkLast = speaker;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TimeoutCycles) begin
			$display("timeout after %0d cycles, the game stopped making progress", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// rest before holding one button and releasing it
	task automatic pressColor(input color_t c, input logic expectLed);
		int hold;
		int rest;
		logic seen;
		hold = `DEBOUNCE_CYCLES + 8 + {$random(seed)} % 16;
		rest = `DEBOUNCE_CYCLES + 8 + {$random(seed)} % 16;
		seen = 1'b0;
		repeat (rest) @(negedge clk);
		@(posedge clk) buttonsN <= ~(buttons_t'(1) << c);
		repeat (hold) begin
			@(negedge clk);
			if (led.on) begin
				seen = 1'b1;
				colorMatch("led.color", led.color, c);
			end
		end
		@(posedge clk) buttonsN <= '1;
		if (expectLed && !seen) begin
			reportProblem($sformatf("button %0d was held but its led never lit", c));
		end
	endtask

	// a bounce shorter than the debounce time must stay dark
	task automatic shortPulse(input color_t c);
		for (int k = 0; k < 2 * `DEBOUNCE_CYCLES + 4; k++) begin
			@(posedge clk);
			buttonsN <= (k < `DEBOUNCE_CYCLES - 3) ? ~(buttons_t'(1) << c) : '1;
			@(negedge clk);
			bitMatch("led.on", led.on, 1'b0);
		end
	endtask

	// record the colours simon plays in round r
	task automatic watchSimon(input int r);
		int waited;
		int onCycles;
		for (int i = 0; i < r; i++) begin
			waited = 0;
			do begin
				@(negedge clk);
				waited++;
			end while (!led.on && waited < 4 * `NOTE_CYCLES + `GAP_CYCLES + 100);
			if (!led.on) begin
				reportProblem($sformatf("colour %0d of round %0d never lit", i, r));
				return;
			end
			if (i == 0) begin
				scoreMatch("score", score, score_t'(r - 1));
			end
			seq[i] = led.color;
			edgeCount = 0;
			onCycles = 0;
			while (led.on && onCycles <= `TONE_CYCLES + 10) begin
				onCycles++;
				@(negedge clk);
			end
			if (onCycles != `TONE_CYCLES) begin
				reportProblem($sformatf("simon tone lasted %0d cycles instead of %0d",
					onCycles, `TONE_CYCLES));
			end
			// a tone with no checked speaker edges was silent
			if (edgeCount < 2) begin
				reportProblem($sformatf("colour %0d of round %0d was silent", i, r));
			end
		end
		// a round plays no more than r colours
		repeat (`GAP_CYCLES + 20) begin
			@(negedge clk);
			if (led.on) begin
				reportProblem($sformatf("round %0d lit more than %0d colours", r, r));
			end
		end
		for (int i = 0; i < r - 1; i++) begin
			colorMatch("sequence", seq[i], prevSeq[i]);
		end
		prevSeq = seq;
	endtask

	// wait out the pause and check the three notes in the middle of each
	task automatic listenMelody(input toneIdx_t a, input toneIdx_t b, input toneIdx_t c);
		int waited;
		toneIdx_t note;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!(speaker && !led.on) && waited < 2 * `NOTE_CYCLES + 100);
		if (!(speaker && !led.on)) begin
			reportProblem("melody never started");
			return;
		end
		for (int e = 1; e <= 2 * `NOTE_CYCLES + 100; e++) begin
			@(posedge clk);
			for (int k = 0; k < 3; k++) begin
				note = (k == 0) ? a : (k == 1) ? b : c;
				if (e == k * `NOTE_CYCLES + 8) begin
					melodyHalf = halfFor(note);
					edgeCount = 0;
				end else if (e == k * `NOTE_CYCLES + 100) begin
					melodyHalf = 0;
					if (edgeCount < 2) begin
						reportProblem($sformatf("melody note %0d did not sound", note));
					end
				end
			end
		end
	endtask

	initial begin
		seed = 32'h569aa529;
		clk = 1'b0;
		reset = 1'b1;
		buttonsN = '1;
		valueErrors = 0;
		otherErrors = 0;
		cycles = 0;
		melodyHalf = 0;
		edgeCount = 0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		// quiet and dark until the start press
		repeat (40) begin
			@(negedge clk);
			bitMatch("led.on", led.on, 1'b0);
			bitMatch("speaker", speaker, 1'b0);
			scoreMatch("score", score, '0);
		end
		pressColor(2'd0, 1'b0);
		for (int r = 1; r <= Rounds; r++) begin
			watchSimon(r);
			shortPulse(color_t'({$random(seed)} % 4));
			if (r < Rounds) begin
				for (int i = 0; i < r; i++) begin
					pressColor(seq[i], 1'b1);
				end
				listenMelody(3'd4, 3'd5, 3'd6);
			end else begin
				// wrong first colour ends the game
				pressColor(seq[0] + 2'd1, 1'b1);
				listenMelody(3'd2, 3'd1, 3'd0);
			end
		end
		repeat (`NOTE_CYCLES) @(negedge clk);
		scoreMatch("score", score, '0);
		repeat (200) begin
			@(negedge clk);
			bitMatch("led.on", led.on, 1'b0);
		end
		$display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
		if (valueErrors == 0 && otherErrors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/simonPkg.sv
source/buttonDebouncer.sv
source/sequenceGenerator.sv
source/toneTimer.sv
source/toneSynth.sv
source/gameControl.sv
source/simonTop.sv
testbench/simonTop_chk.sv
testbench/simonTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the simon testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module simonTb
output=$(./obj_dir/VsimonTb)
echo "$output"
echo "$output" | grep -q "^NO ERRORS$"
